/* source/video_pkg.sv */
//--------------------------------------------------------------------
// Shared definitions for the CRT controller
// APB bus widths, register offsets and timing field layout
//--------------------------------------------------------------------

`default_nettype none

package video_pkg;

    //--------------------------------------------------------------------
    // Widths
    //--------------------------------------------------------------------
    // Pixel and line counts
    localparam int coord_w    = 12;

    localparam int apb_addr_w = 8;
    localparam int apb_data_w = 32;

    //--------------------------------------------------------------------
    // Register map
    //--------------------------------------------------------------------
    // Bit 0 enable, bit 1 hsync invert, bit 2 vsync invert
    localparam logic [apb_addr_w-1:0] reg_ctrl   = 8'h00;

    // Active pixels low, total pixels high
    localparam logic [apb_addr_w-1:0] reg_h_size = 8'h04;

    // Hsync start low, hsync end high
    localparam logic [apb_addr_w-1:0] reg_h_sync = 8'h08;

    // Active lines low, total lines high
    localparam logic [apb_addr_w-1:0] reg_v_size = 8'h0C;

    // Vsync start low, vsync end high
    localparam logic [apb_addr_w-1:0] reg_v_sync = 8'h10;

    // Upper field position in the timing registers
    localparam int hi_field_lsb = 16;

endpackage

`default_nettype wire

/* source/crtc_regs.sv */
//--------------------------------------------------------------------
// APB configuration registers for the CRT controller
// Control word plus four timing registers, zero wait states
// Unmapped offsets answer with pslverr and read zero
//--------------------------------------------------------------------

`timescale 1ns/1ps
`default_nettype none

module crtc_regs (
    // Inputs
     input  logic                             clk_i
    ,input  logic                             rst_i
    ,input  logic [video_pkg::apb_addr_w-1:0] paddr_i
    ,input  logic                             psel_i
    ,input  logic                             penable_i
    ,input  logic                             pwrite_i
    ,input  logic [video_pkg::apb_data_w-1:0] pwdata_i

    // Outputs
    ,output logic [video_pkg::apb_data_w-1:0] prdata_o
    ,output logic                             pready_o
    ,output logic                             pslverr_o
    ,output logic                             enable_o
    ,output logic                             hinvert_o
    ,output logic                             vinvert_o
    ,output logic [video_pkg::coord_w-1:0]    h_active_o
    ,output logic [video_pkg::coord_w-1:0]    h_total_o
    ,output logic [video_pkg::coord_w-1:0]    h_sync_start_o
    ,output logic [video_pkg::coord_w-1:0]    h_sync_end_o
    ,output logic [video_pkg::coord_w-1:0]    v_active_o
    ,output logic [video_pkg::coord_w-1:0]    v_total_o
    ,output logic [video_pkg::coord_w-1:0]    v_sync_start_o
    ,output logic [video_pkg::coord_w-1:0]    v_sync_end_o
);

logic [2:0]                          ctrl_q;
logic                                wr_en_w;
logic                                addr_hit_w;
logic [video_pkg::apb_data_w-1:0]    rdata_w;
logic [video_pkg::coord_w-1:0]       lo_w;
logic [video_pkg::coord_w-1:0]       hi_w;

//--------------------------------------------------------------------
// Write path
//--------------------------------------------------------------------
assign wr_en_w = psel_i & penable_i & pwrite_i;
assign lo_w    = pwdata_i[video_pkg::coord_w-1:0];
assign hi_w    = pwdata_i[video_pkg::hi_field_lsb +: video_pkg::coord_w];

always_ff @(posedge clk_i or posedge rst_i) begin
    if (rst_i) begin
        ctrl_q         <= '0;
        h_active_o     <= '0;
        h_total_o      <= '0;
        h_sync_start_o <= '0;
        h_sync_end_o   <= '0;
        v_active_o     <= '0;
        v_total_o      <= '0;
        v_sync_start_o <= '0;
        v_sync_end_o   <= '0;
    end else if (wr_en_w) begin
        case (paddr_i)
            video_pkg::reg_ctrl: begin
                ctrl_q <= pwdata_i[2:0];
            end
            video_pkg::reg_h_size: begin
                h_active_o <= lo_w;
                h_total_o  <= hi_w;
            end
            video_pkg::reg_h_sync: begin
                h_sync_start_o <= lo_w;
                h_sync_end_o   <= hi_w;
            end
            video_pkg::reg_v_size: begin
                v_active_o <= lo_w;
                v_total_o  <= hi_w;
            end
            video_pkg::reg_v_sync: begin
                v_sync_start_o <= lo_w;
                v_sync_end_o   <= hi_w;
            end
            default: begin
                // Unmapped, nothing stored
            end
        endcase
    end
end

//--------------------------------------------------------------------
// Read path
//--------------------------------------------------------------------
always_comb begin
    rdata_w    = '0;
    addr_hit_w = 1'b1;
    case (paddr_i)
        video_pkg::reg_ctrl: begin
            rdata_w[2:0] = ctrl_q;
        end
        video_pkg::reg_h_size: begin
            rdata_w[video_pkg::coord_w-1:0]                         = h_active_o;
            rdata_w[video_pkg::hi_field_lsb +: video_pkg::coord_w] = h_total_o;
        end
        video_pkg::reg_h_sync: begin
            rdata_w[video_pkg::coord_w-1:0]                         = h_sync_start_o;
            rdata_w[video_pkg::hi_field_lsb +: video_pkg::coord_w] = h_sync_end_o;
        end
        video_pkg::reg_v_size: begin
            rdata_w[video_pkg::coord_w-1:0]                         = v_active_o;
            rdata_w[video_pkg::hi_field_lsb +: video_pkg::coord_w] = v_total_o;
        end
        video_pkg::reg_v_sync: begin
            rdata_w[video_pkg::coord_w-1:0]                         = v_sync_start_o;
            rdata_w[video_pkg::hi_field_lsb +: video_pkg::coord_w] = v_sync_end_o;
        end
        default: begin
            addr_hit_w = 1'b0;
        end
    endcase
end

assign prdata_o  = rdata_w;
assign pready_o  = 1'b1;
assign pslverr_o = psel_i & penable_i & ~addr_hit_w;

// Control bits
assign enable_o  = ctrl_q[0];
assign hinvert_o = ctrl_q[1];
assign vinvert_o = ctrl_q[2];

endmodule

`default_nettype wire

/* source/line_counter.sv */
//--------------------------------------------------------------------
// Horizontal pixel counter
// Line end and visibility decode, registered x and hsync
//--------------------------------------------------------------------

`timescale 1ns/1ps
`default_nettype none

module line_counter (
    // Inputs
     input  logic                          clk_i
    ,input  logic                          rst_i
    ,input  logic                          enable_i
    ,input  logic                          hinvert_i
    ,input  logic [video_pkg::coord_w-1:0] h_active_i
    ,input  logic [video_pkg::coord_w-1:0] h_total_i
    ,input  logic [video_pkg::coord_w-1:0] h_sync_start_i
    ,input  logic [video_pkg::coord_w-1:0] h_sync_end_i

    // Outputs
    ,output logic                          line_end_o
    ,output logic                          h_visible_o
    ,output logic [video_pkg::coord_w-1:0] x_o
    ,output logic                          hsync_o
);

logic [video_pkg::coord_w-1:0] h_cnt_q;
logic [video_pkg::coord_w-1:0] h_last_w;
logic                          hsync_raw_w;

assign h_last_w    = h_total_i - 1'b1;
assign line_end_o  = enable_i & (h_cnt_q == h_last_w);
assign h_visible_o = (h_cnt_q < h_active_i);

// Raw sync, forced low while disabled
assign hsync_raw_w = enable_i & (h_cnt_q >= h_sync_start_i) & (h_cnt_q < h_sync_end_i);

always_ff @(posedge clk_i or posedge rst_i) begin
    if (rst_i) begin
        h_cnt_q <= '0;
    end else if (!enable_i || line_end_o) begin
        h_cnt_q <= '0;
    end else begin
        h_cnt_q <= h_cnt_q + 1'b1;
    end
end

// One cycle behind the count
always_ff @(posedge clk_i or posedge rst_i) begin
    if (rst_i) begin
        x_o     <= '0;
        hsync_o <= 1'b0;
    end else begin
        x_o     <= h_cnt_q;
        hsync_o <= hsync_raw_w ^ hinvert_i;
    end
end

endmodule

`default_nettype wire

/* source/frame_counter.sv */
//--------------------------------------------------------------------
// Vertical line counter
// Registered y, vsync and data enable
//--------------------------------------------------------------------

`timescale 1ns/1ps
`default_nettype none

module frame_counter (
    // Inputs
     input  logic                          clk_i
    ,input  logic                          rst_i
    ,input  logic                          enable_i
    ,input  logic                          vinvert_i
    ,input  logic                          line_end_i
    ,input  logic                          h_visible_i
    ,input  logic [video_pkg::coord_w-1:0] v_active_i
    ,input  logic [video_pkg::coord_w-1:0] v_total_i
    ,input  logic [video_pkg::coord_w-1:0] v_sync_start_i
    ,input  logic [video_pkg::coord_w-1:0] v_sync_end_i

    // Outputs
    ,output logic [video_pkg::coord_w-1:0] y_o
    ,output logic                          vsync_o
    ,output logic                          de_o
);

logic [video_pkg::coord_w-1:0] v_cnt_q;
logic [video_pkg::coord_w-1:0] v_last_w;
logic                          vsync_raw_w;
logic                          de_w;

assign v_last_w    = v_total_i - 1'b1;
assign vsync_raw_w = enable_i & (v_cnt_q >= v_sync_start_i) & (v_cnt_q < v_sync_end_i);
assign de_w        = enable_i & h_visible_i & (v_cnt_q < v_active_i);

// Line count steps once per horizontal wrap
always_ff @(posedge clk_i or posedge rst_i) begin
    if (rst_i) begin
        v_cnt_q <= '0;
    end else if (!enable_i) begin
        v_cnt_q <= '0;
    end else if (line_end_i) begin
        if (v_cnt_q == v_last_w) begin
            v_cnt_q <= '0;
        end else begin
            v_cnt_q <= v_cnt_q + 1'b1;
        end
    end
end

// Same latency as the x path
always_ff @(posedge clk_i or posedge rst_i) begin
    if (rst_i) begin
        y_o     <= '0;
        vsync_o <= 1'b0;
        de_o    <= 1'b0;
    end else begin
        y_o     <= v_cnt_q;
        vsync_o <= vsync_raw_w ^ vinvert_i;
        de_o    <= de_w;
    end
end

endmodule

`default_nettype wire

/* source/video_top.sv */
//--------------------------------------------------------------------
// CRT controller top level
// APB register block feeding the horizontal and vertical counters
//--------------------------------------------------------------------

`timescale 1ns/1ps
`default_nettype none

module video_top (
    // Inputs
     input  logic                             clk_i
    ,input  logic                             rst_i
    ,input  logic [video_pkg::apb_addr_w-1:0] paddr_i
    ,input  logic                             psel_i
    ,input  logic                             penable_i
    ,input  logic                             pwrite_i
    ,input  logic [video_pkg::apb_data_w-1:0] pwdata_i

    // Outputs
    ,output logic [video_pkg::apb_data_w-1:0] prdata_o
    ,output logic                             pready_o
    ,output logic                             pslverr_o
    ,output logic [video_pkg::coord_w-1:0]    x_o
    ,output logic [video_pkg::coord_w-1:0]    y_o
    ,output logic                             de_o
    ,output logic                             hsync_o
    ,output logic                             vsync_o
);

logic                          enable_w;
logic                          hinvert_w;
logic                          vinvert_w;
logic [video_pkg::coord_w-1:0] h_active_w;
logic [video_pkg::coord_w-1:0] h_total_w;
logic [video_pkg::coord_w-1:0] h_sync_start_w;
logic [video_pkg::coord_w-1:0] h_sync_end_w;
logic [video_pkg::coord_w-1:0] v_active_w;
logic [video_pkg::coord_w-1:0] v_total_w;
logic [video_pkg::coord_w-1:0] v_sync_start_w;
logic [video_pkg::coord_w-1:0] v_sync_end_w;
logic                          line_end_w;
logic                          h_visible_w;

crtc_regs u_regs (
     .clk_i(clk_i)
    ,.rst_i(rst_i)
    ,.paddr_i(paddr_i)
    ,.psel_i(psel_i)
    ,.penable_i(penable_i)
    ,.pwrite_i(pwrite_i)
    ,.pwdata_i(pwdata_i)
    ,.prdata_o(prdata_o)
    ,.pready_o(pready_o)
    ,.pslverr_o(pslverr_o)
    ,.enable_o(enable_w)
    ,.hinvert_o(hinvert_w)
    ,.vinvert_o(vinvert_w)
    ,.h_active_o(h_active_w)
    ,.h_total_o(h_total_w)
    ,.h_sync_start_o(h_sync_start_w)
    ,.h_sync_end_o(h_sync_end_w)
    ,.v_active_o(v_active_w)
    ,.v_total_o(v_total_w)
    ,.v_sync_start_o(v_sync_start_w)
    ,.v_sync_end_o(v_sync_end_w)
);

line_counter u_line (
     .clk_i(clk_i)
    ,.rst_i(rst_i)
    ,.enable_i(enable_w)
    ,.hinvert_i(hinvert_w)
    ,.h_active_i(h_active_w)
    ,.h_total_i(h_total_w)
    ,.h_sync_start_i(h_sync_start_w)
    ,.h_sync_end_i(h_sync_end_w)
    ,.line_end_o(line_end_w)
    ,.h_visible_o(h_visible_w)
    ,.x_o(x_o)
    ,.hsync_o(hsync_o)
);

frame_counter u_frame (
     .clk_i(clk_i)
    ,.rst_i(rst_i)
    ,.enable_i(enable_w)
    ,.vinvert_i(vinvert_w)
    ,.line_end_i(line_end_w)
    ,.h_visible_i(h_visible_w)
    ,.v_active_i(v_active_w)
    ,.v_total_i(v_total_w)
    ,.v_sync_start_i(v_sync_start_w)
    ,.v_sync_end_i(v_sync_end_w)
    ,.y_o(y_o)
    ,.vsync_o(vsync_o)
    ,.de_o(de_o)
);

endmodule

`default_nettype wire

/* verif/video_top_sva.sv */
//--------------------------------------------------------------------
// Concurrent assertions bound into the CRT controller top level
// APB ready, data enable against control and x range
//--------------------------------------------------------------------

`timescale 1ns/1ps
`default_nettype none

module video_top_sva (
     input wire                          clk_i
    ,input wire                          rst_i
    ,input wire                          psel_i
    ,input wire                          penable_i
    ,input wire                          pready_i
    ,input wire                          enable_i
    ,input wire                          de_i
    ,input wire [video_pkg::coord_w-1:0] x_i
    ,input wire [video_pkg::coord_w-1:0] h_total_i
);

// Zero wait states
assert property (@(posedge clk_i) disable iff (rst_i) psel_i && penable_i |-> pready_i)
    else $error("pready low in an APB access cycle");

// de is registered one clock after the enable it was decoded with
assert property (@(posedge clk_i) disable iff (rst_i) !$past(enable_i) |-> !de_i)
    else $error("de high while the raster is disabled");

assert property (@(posedge clk_i) disable iff (rst_i) de_i |-> x_i < h_total_i)
    else $error("x outside the line while de is high");

endmodule

bind video_top video_top_sva sva0 (
     .clk_i(clk_i)
    ,.rst_i(rst_i)
    ,.psel_i(psel_i)
    ,.penable_i(penable_i)
    ,.pready_i(pready_o)
    ,.enable_i(enable_w)
    ,.de_i(de_o)
    ,.x_i(x_o)
    ,.h_total_i(h_total_w)
);

`default_nettype wire

/* verif/tb_video_top.sv */
//--------------------------------------------------------------------
// Testbench for the CRT controller top level
// APB driver, stimulus file reader, raster measurement and checks
//--------------------------------------------------------------------

`timescale 1ns/1ps
`default_nettype none

module tb_video_top;

logic                             clk_i;
logic                             rst_i;
logic [video_pkg::apb_addr_w-1:0] paddr_i;
logic                             psel_i;
logic                             penable_i;
logic                             pwrite_i;
logic [video_pkg::apb_data_w-1:0] pwdata_i;
logic [video_pkg::apb_data_w-1:0] prdata_o;
logic                             pready_o;
logic                             pslverr_o;
logic [video_pkg::coord_w-1:0]    x_o;
logic [video_pkg::coord_w-1:0]    y_o;
logic                             de_o;
logic                             hsync_o;
logic                             vsync_o;

integer     seed;
logic [2:0] ctrl_s;
int         h_active;
int         h_total;
int         hs_start;
int         hs_end;
int         v_active;
int         v_total;
int         vs_start;
int         vs_end;

video_top dut0 (
     .clk_i(clk_i)
    ,.rst_i(rst_i)
    ,.paddr_i(paddr_i)
    ,.psel_i(psel_i)
    ,.penable_i(penable_i)
    ,.pwrite_i(pwrite_i)
    ,.pwdata_i(pwdata_i)
    ,.prdata_o(prdata_o)
    ,.pready_o(pready_o)
    ,.pslverr_o(pslverr_o)
    ,.x_o(x_o)
    ,.y_o(y_o)
    ,.de_o(de_o)
    ,.hsync_o(hsync_o)
    ,.vsync_o(vsync_o)
);

always #10 clk_i = ~clk_i;

//--------------------------------------------------------------------
// Reporting
//--------------------------------------------------------------------
task automatic stop_run();
    $display("ERRORS FOUND");
    $fatal(1, "simulation stopped at first error");
endtask

task automatic check(input string test, input string item, input int expected,
                     input int actual);
    if (expected != actual) begin
        $display("FAIL %s %s expected 0x%0h actual 0x%0h", test, item, expected, actual);
        stop_run();
    end
endtask

//--------------------------------------------------------------------
// APB master
//--------------------------------------------------------------------
task automatic idle_gap();
    int n;
    n = $random(seed) & 3;
    repeat (n) @(posedge clk_i);
endtask

// The five register offsets of the map
function automatic logic is_mapped(input logic [7:0] addr);
    return (addr == 8'h00) || (addr == 8'h04) || (addr == 8'h08) ||
           (addr == 8'h0c) || (addr == 8'h10);
endfunction

task automatic apb_write(input logic [7:0] addr, input logic [31:0] data);
    idle_gap();
    @(posedge clk_i);
    paddr_i   <= addr;
    pwdata_i  <= data;
    pwrite_i  <= 1'b1;
    psel_i    <= 1'b1;
    penable_i <= 1'b0;
    @(posedge clk_i);
    penable_i <= 1'b1;
    // Mid access cycle
    @(negedge clk_i);
    check($sformatf("write_%02h", addr), "pready", 1, pready_o);
    check($sformatf("write_%02h", addr), "pslverr", !is_mapped(addr), pslverr_o);
    @(posedge clk_i);
    psel_i    <= 1'b0;
    penable_i <= 1'b0;
    pwrite_i  <= 1'b0;
endtask

task automatic apb_read(input logic [7:0] addr, output logic [31:0] data, output logic err);
    idle_gap();
    @(posedge clk_i);
    paddr_i   <= addr;
    pwrite_i  <= 1'b0;
    psel_i    <= 1'b1;
    penable_i <= 1'b0;
    @(posedge clk_i);
    penable_i <= 1'b1;
    // Mid access cycle
    @(negedge clk_i);
    data = prdata_o;
    err  = pslverr_o;
    check($sformatf("read_%02h", addr), "pready", 1, pready_o);
    @(posedge clk_i);
    psel_i    <= 1'b0;
    penable_i <= 1'b0;
endtask

// Expected timing follows the register layout
task automatic update_shadow(input logic [7:0] addr, input logic [31:0] data);
    case (addr)
        video_pkg::reg_ctrl: ctrl_s = data[2:0];
        video_pkg::reg_h_size: begin
            h_active = data & 32'hfff;
            h_total  = (data >> 16) & 32'hfff;
        end
        video_pkg::reg_h_sync: begin
            hs_start = data & 32'hfff;
            hs_end   = (data >> 16) & 32'hfff;
        end
        video_pkg::reg_v_size: begin
            v_active = data & 32'hfff;
            v_total  = (data >> 16) & 32'hfff;
        end
        video_pkg::reg_v_sync: begin
            vs_start = data & 32'hfff;
            vs_end   = (data >> 16) & 32'hfff;
        end
        default: ;
    endcase
endtask

//--------------------------------------------------------------------
// Raster measurement, sampled on the falling edge
//--------------------------------------------------------------------
function automatic logic probe(input int sel);
    case (sel)
        0:       return hsync_o;
        1:       return vsync_o;
        default: return de_o;
    endcase
endfunction

task automatic wait_level(input int sel, input logic level, input int limit,
                          input string what, output int cycles);
    cycles = 0;
    while (probe(sel) !== level) begin
        if (cycles >= limit) begin
            $display("Timeout: %s never came within %0d cycles", what, limit);
            stop_run();
        end
        @(negedge clk_i);
        cycles++;
    end
endtask

task automatic measure(input string name);
    int   lim;
    int   n;
    int   width;
    int   gap;
    int   count;
    int   i;
    int   fx;
    int   fy;
    int   lx;
    int   ly;
    logic h_act;
    logic v_act;
    lim   = 2 * h_total * v_total + 16;
    h_act = ~ctrl_s[1];
    v_act = ~ctrl_s[2];
    @(negedge clk_i);
    wait_level(0, ~h_act, lim, "hsync idle level", n);
    wait_level(0, h_act, lim, "hsync pulse start", n);
    wait_level(0, ~h_act, lim, "hsync pulse end", width);
    wait_level(0, h_act, lim, "next hsync pulse", gap);
    check(name, "hsync width", hs_end - hs_start, width);
    check(name, "hsync period", h_total, width + gap);
    wait_level(1, ~v_act, lim, "vsync idle level", n);
    wait_level(1, v_act, lim, "vsync pulse start", n);
    wait_level(1, ~v_act, lim, "vsync pulse end", width);
    wait_level(1, v_act, lim, "next vsync pulse", gap);
    check(name, "vsync width", (vs_end - vs_start) * h_total, width);
    check(name, "vsync period", h_total * v_total, width + gap);
    // Vsync sits after the active lines, so the next de opens a frame
    wait_level(2, 1'b1, lim, "data enable", n);
    fx    = x_o;
    fy    = y_o;
    lx    = 0;
    ly    = 0;
    count = 0;
    for (i = 0; i < h_total * v_total; i++) begin
        if (de_o) begin
            count++;
            lx = x_o;
            ly = y_o;
        end
        @(negedge clk_i);
    end
    check(name, "de cycles", h_active * v_active, count);
    check(name, "first x", 0, fx);
    check(name, "first y", 0, fy);
    check(name, "last x", h_active - 1, lx);
    check(name, "last y", v_active - 1, ly);
endtask

// Disabled raster holds de low and syncs at their idle level
task automatic check_quiet(input string name);
    int i;
    repeat (3) @(negedge clk_i);
    for (i = 0; i < h_total * v_total; i++) begin
        check(name, "de", 0, de_o);
        check(name, "hsync idle", ctrl_s[1], hsync_o);
        check(name, "vsync idle", ctrl_s[2], vsync_o);
        @(negedge clk_i);
    end
endtask

//--------------------------------------------------------------------
// Main sequence
//--------------------------------------------------------------------
initial begin
    integer      fd;
    int          n;
    int          cmd_count;
    string       line;
    string       word;
    string       name;
    logic [7:0]  addr;
    logic [31:0] data;
    logic [31:0] exp_data;
    logic [31:0] exp_err;
    logic [31:0] rd;
    logic        err;
    seed      = 32'h39b5_3fea;
    clk_i     = 1'b0;
    rst_i     = 1'b1;
    paddr_i   = '0;
    psel_i    = 1'b0;
    penable_i = 1'b0;
    pwrite_i  = 1'b0;
    pwdata_i  = '0;
    cmd_count = 0;
    ctrl_s    = '0;
    update_shadow(8'h04, 32'h0);
    update_shadow(8'h08, 32'h0);
    update_shadow(8'h0c, 32'h0);
    update_shadow(8'h10, 32'h0);
    repeat (8) @(posedge clk_i);
    rst_i <= 1'b0;
    @(negedge clk_i);
    check("reset", "de_o", 0, de_o);
    check("reset", "hsync_o", 0, hsync_o);
    check("reset", "vsync_o", 0, vsync_o);
    check("reset", "pslverr_o", 0, pslverr_o);
    fd = $fopen("verif/crtc_input.txt", "r");
    if (fd == 0) begin
        $display("Could not open the stimulus file verif/crtc_input.txt");
        stop_run();
    end
    while (!$feof(fd)) begin
        line = "";
        n    = $fgets(line, fd);
        if ($sscanf(line, "%s", word) == 1) begin
            if (word == "W") begin
                n = $sscanf(line, "%s %h %h", word, addr, data);
                apb_write(addr, data);
                update_shadow(addr, data);
                cmd_count++;
            end else if (word == "R") begin
                n = $sscanf(line, "%s %h %h %h", word, addr, exp_data, exp_err);
                apb_read(addr, rd, err);
                check($sformatf("read_%02h", addr), "prdata", exp_data, rd);
                check($sformatf("read_%02h", addr), "pslverr", exp_err, err);
                cmd_count++;
            end else if (word == "M") begin
                n = $sscanf(line, "%s %s", word, name);
                measure(name);
                cmd_count++;
            end else if (word == "Q") begin
                n = $sscanf(line, "%s %s", word, name);
                check_quiet(name);
                cmd_count++;
            end
        end
    end
    $fclose(fd);
    if (cmd_count > 0) begin
        $display("NO ERRORS");
        $finish;
    end else begin
        $display("The stimulus file held no commands");
        stop_run();
    end
end

endmodule

`default_nettype wire

/* verif/crtc_input.txt */
# W addr data | R addr expected_data expected_pslverr (all hex)
# M test_name measures one frame | Q test_name checks a disabled frame
R 00 00000000 0
R 04 00000000 0
R 08 00000000 0
R 0C 00000000 0
R 10 00000000 0
W 04 F123F456
R 04 01230456 0
W 08 FFFFFFFF
R 08 0FFF0FFF 0
W 00 FFFFFFF8
R 00 00000000 0
W 20 12345678
R 20 00000000 1
W 04 00180010
W 08 00150012
W 0C 000A0006
W 10 00090007
R 04 00180010 0
R 08 00150012 0
R 0C 000A0006 0
R 10 00090007 0
W 00 00000001
M normal_polarity
W 00 00000000
Q disabled
W 04 00200014
W 08 001A0016
W 0C 000C0008
W 10 000B0009
W 00 00000007
R 00 00000007 0
M inverted_polarity
W 00 00000006
Q disabled_inverted

/* vlog.f */
source/video_pkg.sv
source/crtc_regs.sv
source/line_counter.sv
source/frame_counter.sv
source/video_top.sv
verif/video_top_sva.sv
verif/tb_video_top.sv
